//--- source/ifu_consts.svh
// Width and depth constants of the instruction fetch unit
// Include in any file that sizes a port, a counter or the queue
`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

// Fetch address width
`define IFU_XLEN 32

// Instruction memory data width
`define IFU_IMEM_DWIDTH 32

// Queue depth in halfwords
`define IFU_Q_SIZE_HALF 4

// Outstanding-read and discard counters
`define IFU_TXN_CNT_W 3

// Free-word count, holds 0 up to IFU_Q_SIZE_HALF/2
`define IFU_Q_FREE_W_W 2

`endif

//--- source/ifu_pkg.sv
// Types shared by the fetch unit modules: state and opcode enums, port bundles
// Modules pull these in with a wildcard import in their header
`default_nettype none
`include "ifu_consts.svh"

package ifu_pkg;

    typedef enum logic {
        FSM_IDLE,
        FSM_FETCH
    } fsm_state_e;

    typedef enum logic [1:0] {
        RESP_IDLE,
        RESP_RDY_OK,
        RESP_RDY_ER
    } mem_resp_e;

    // Upper halfword named first, lower halfword second
    typedef enum logic [2:0] {
        RDATA_NONE,
        RDATA_RVI_HI_RVI_LO,     // Whole 32-bit instruction
        RDATA_RVC_RVC,
        RDATA_RVI_LO_RVC,
        RDATA_RVC_RVI_HI,
        RDATA_RVI_LO_RVI_HI,
        RDATA_RVC_NV,            // Low half skipped after unaligned redirect
        RDATA_RVI_LO_NV
    } rdata_ident_e;

    typedef enum logic [1:0] {
        WE_NONE,
        WE_FULL,                 // Both halfwords
        WE_HI                    // Upper halfword only
    } q_we_e;

    typedef struct packed {
        logic                   new_pc_req;
        logic [`IFU_XLEN-1:0]   new_pc;
        logic                   stop_fetch;
    } redirect_t;

    typedef struct packed {
        mem_resp_e                      resp;
        logic [`IFU_IMEM_DWIDTH-1:0]    rdata;
    } imem_resp_t;

    // ok and er are already masked by discard
    typedef struct packed {
        logic   ok;
        logic   er;
        logic   discard;
    } resp_evt_t;

    typedef struct packed {
        logic [`IFU_IMEM_DWIDTH-1:0]    instr;
        logic                           imem_err;
        logic                           vd;
    } idu_out_t;

endpackage
`default_nettype wire

//--- source/fetch_fsm.sv
// Idle/fetch control of the fetch unit
// Leaves fetch on stop_fetch or on a kept memory error
`timescale 1ns/1ns
`default_nettype none

module fetch_fsm
    import ifu_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire redirect_t  redir,
    input  wire resp_evt_t  evt,
    output fsm_state_e      state,
    output logic            busy
);

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        state <= FSM_IDLE;
    end else begin
        case (state)
            FSM_IDLE: begin
                if (redir.new_pc_req & ~redir.stop_fetch) begin
                    state <= FSM_FETCH;
                end
            end
            FSM_FETCH: begin
                // A redirect in the error cycle keeps fetching
                if (redir.stop_fetch | (evt.er & ~redir.new_pc_req)) begin
                    state <= FSM_IDLE;
                end
            end
            default: state <= FSM_IDLE;
        endcase
    end
end

assign busy = (state == FSM_FETCH);

endmodule
`default_nettype wire

//--- source/txn_tracker.sv
// Memory request side of the fetch unit: fetch address, outstanding reads
// and the count of stale responses still to drop after a redirect or error
`timescale 1ns/1ns
`default_nettype none
`include "ifu_consts.svh"

module txn_tracker
    import ifu_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire redirect_t              redir,
    input  wire mem_resp_e              resp,
    input  wire fsm_state_e             state,
    input  wire [`IFU_Q_FREE_W_W-1:0]   q_free_w,
    input  wire                         imem_req_ack,
    output logic                        imem_req,
    output logic [`IFU_XLEN-1:0]        imem_addr,
    output resp_evt_t                   evt
);

logic [`IFU_XLEN-1:2]       addr_r;           // Next word to fetch
logic [`IFU_TXN_CNT_W-1:0]  pend_cnt;         // Sent, not yet answered
logic [`IFU_TXN_CNT_W-1:0]  disc_cnt;         // Answers to throw away
logic [`IFU_TXN_CNT_W-1:0]  disc_cnt_new;
logic [`IFU_TXN_CNT_W-1:0]  vd_pend_cnt;      // Reads still worth keeping
logic                       pend_full;
logic                       raw_ok;
logic                       raw_er;
logic                       raw_vd;
logic                       discard;
logic                       req_acc;

// --------------------------------------------------------------------------
// Response decode
// --------------------------------------------------------------------------
assign raw_ok  = (resp == RESP_RDY_OK);
assign raw_er  = (resp == RESP_RDY_ER);
assign raw_vd  = raw_ok | raw_er;
assign discard = |disc_cnt;

assign evt.ok      = raw_ok & ~discard;
assign evt.er      = raw_er & ~discard;
assign evt.discard = discard;

// --------------------------------------------------------------------------
// Request and address
// --------------------------------------------------------------------------
assign pend_full   = &pend_cnt;
assign vd_pend_cnt = pend_cnt - disc_cnt;

assign imem_req = (redir.new_pc_req & ~pend_full)
                | ((state == FSM_FETCH) & ~pend_full
                   & (`IFU_TXN_CNT_W'(q_free_w) > vd_pend_cnt));

assign imem_addr = {(redir.new_pc_req ? redir.new_pc[`IFU_XLEN-1:2] : addr_r), 2'b00};
assign req_acc   = imem_req & imem_req_ack;

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        addr_r <= '0;
    end else if (req_acc) begin
        addr_r <= imem_addr[`IFU_XLEN-1:2] + 1'b1;
    end else if (redir.new_pc_req) begin
        addr_r <= redir.new_pc[`IFU_XLEN-1:2];
    end
end

// --------------------------------------------------------------------------
// Counters
// --------------------------------------------------------------------------
always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        pend_cnt <= '0;
    end else if (req_acc & ~raw_vd) begin
        pend_cnt <= pend_cnt + 1'b1;
    end else if (~req_acc & raw_vd) begin
        pend_cnt <= pend_cnt - 1'b1;
    end
end

// Reads issued in an error cycle are stale too, so they join the discard count
always_comb begin
    disc_cnt_new = disc_cnt;
    if (redir.new_pc_req) begin
        disc_cnt_new = pend_cnt - `IFU_TXN_CNT_W'(raw_vd);
    end else if (evt.er) begin
        disc_cnt_new = pend_cnt - `IFU_TXN_CNT_W'(~req_acc);
    end else if (raw_vd & discard) begin
        disc_cnt_new = disc_cnt - 1'b1;
    end
end

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        disc_cnt <= '0;
    end else begin
        disc_cnt <= disc_cnt_new;
    end
end

endmodule
`default_nettype wire

//--- source/rdata_classifier.sv
// Sorts each kept response word into its halfword contents and picks the
// queue write, tracking unaligned starts and 32-bit instructions across words
`timescale 1ns/1ns
`default_nettype none
`include "ifu_consts.svh"

module rdata_classifier
    import ifu_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire redirect_t              redir,
    input  wire resp_evt_t              evt,
    input  wire [`IFU_IMEM_DWIDTH-1:0]  rdata,
    output q_we_e                       q_we,
    output logic                        lo_sel
);

logic           new_pc_unaligned;   // Redirect target in upper halfword
logic           rvi_part2;          // Low half of next word ends an RVI
logic           rvi_part2_next;
logic           resp_kept;
logic           hi_rvi;
logic           lo_rvi;
rdata_ident_e   rdata_ident;

assign resp_kept = evt.ok | evt.er;
assign hi_rvi    = &rdata[17:16];
assign lo_rvi    = &rdata[1:0];

always_comb begin
    rdata_ident = RDATA_NONE;
    if (evt.ok) begin
        if (new_pc_unaligned) begin
            rdata_ident = hi_rvi ? RDATA_RVI_LO_NV : RDATA_RVC_NV;
        end else if (rvi_part2) begin
            rdata_ident = hi_rvi ? RDATA_RVI_LO_RVI_HI : RDATA_RVC_RVI_HI;
        end else if (lo_rvi) begin
            rdata_ident = RDATA_RVI_HI_RVI_LO;
        end else begin
            rdata_ident = hi_rvi ? RDATA_RVI_LO_RVC : RDATA_RVC_RVC;
        end
    end
end

assign rvi_part2_next = (rdata_ident == RDATA_RVI_LO_NV)
                      | (rdata_ident == RDATA_RVI_LO_RVI_HI)
                      | (rdata_ident == RDATA_RVI_LO_RVC);

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        new_pc_unaligned <= 1'b0;
        rvi_part2        <= 1'b0;
    end else if (redir.new_pc_req) begin
        new_pc_unaligned <= redir.new_pc[1];
        rvi_part2        <= 1'b0;
    end else if (resp_kept) begin
        new_pc_unaligned <= 1'b0;   // Only the first word is skewed
        rvi_part2        <= rvi_part2_next;
    end
end

always_comb begin
    q_we = WE_NONE;
    if (evt.ok) begin
        case (rdata_ident)
            RDATA_NONE:      q_we = WE_NONE;
            RDATA_RVC_NV,
            RDATA_RVI_LO_NV: q_we = WE_HI;
            default:         q_we = WE_FULL;
        endcase
    end else if (evt.er) begin
        q_we = WE_FULL;   // Error marks both halfwords
    end
end

assign lo_sel = ~new_pc_unaligned;

endmodule
`default_nettype wire

//--- source/instr_queue.sv
// Four-halfword instruction queue between memory responses and decode
// Head is presented combinationally; reads follow the decode handshake
`timescale 1ns/1ns
`default_nettype none
`include "ifu_consts.svh"

module instr_queue
    import ifu_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire redirect_t              redir,
    input  wire resp_evt_t              evt,
    input  wire [`IFU_IMEM_DWIDTH-1:0]  rdata,
    input  wire q_we_e                  q_we,
    input  wire                         lo_sel,
    input  wire                         idu_rdy,
    output logic [`IFU_Q_FREE_W_W-1:0]  q_free_w,
    output idu_out_t                    idu
);

localparam int ADR_W  = $clog2(`IFU_Q_SIZE_HALF);
localparam int PTR_W  = ADR_W + 1;
localparam int OCPD_W = $clog2(`IFU_Q_SIZE_HALF + 1);
localparam int HALF_W = `IFU_IMEM_DWIDTH / 2;

logic [HALF_W-1:0]  q_data [`IFU_Q_SIZE_HALF];
logic               q_err  [`IFU_Q_SIZE_HALF];
logic [PTR_W-1:0]   q_rptr;
logic [PTR_W-1:0]   q_rptr_next;
logic [PTR_W-1:0]   q_wptr;
logic [PTR_W-1:0]   q_wptr_next;
logic [PTR_W-1:0]   q_wptr_inc;
logic [PTR_W-1:0]   q_rd_step;
logic [PTR_W-1:0]   q_wr_step;
logic [OCPD_W-1:0]  q_ocpd_h;           // Halfwords held now
logic [OCPD_W-1:0]  q_free_h_next;      // Free halfwords next cycle
logic               q_empty;
logic               q_flush;
logic [HALF_W-1:0]  q_data_head;
logic [HALF_W-1:0]  q_data_next;
logic               q_err_head;
logic               q_head_single;      // Head leaves as one halfword

// --------------------------------------------------------------------------
// Pointers and fill level
// --------------------------------------------------------------------------
assign q_flush  = redir.new_pc_req | redir.stop_fetch;
assign q_empty  = (q_rptr == q_wptr);
assign q_ocpd_h = OCPD_W'(q_wptr - q_rptr);

assign q_wr_step   = (q_we == WE_FULL) ? PTR_W'(2) : ((q_we == WE_HI) ? PTR_W'(1) : '0);
assign q_wptr_next = q_wptr + q_wr_step;
assign q_wptr_inc  = q_wptr + 1'b1;

always_comb begin
    q_rd_step = '0;
    if (idu.vd & idu_rdy) begin
        q_rd_step = q_head_single ? PTR_W'(1) : PTR_W'(2);
    end
end

assign q_rptr_next   = q_rptr + q_rd_step;
assign q_free_h_next = OCPD_W'(`IFU_Q_SIZE_HALF - OCPD_W'(q_wptr - q_rptr_next));
assign q_free_w      = `IFU_Q_FREE_W_W'(q_free_h_next >> 1);

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        q_rptr <= '0;
        q_wptr <= '0;
    end else if (q_flush) begin
        q_rptr <= '0;
        q_wptr <= '0;
    end else begin
        q_rptr <= q_rptr_next;
        q_wptr <= q_wptr_next;
    end
end

// --------------------------------------------------------------------------
// Storage
// --------------------------------------------------------------------------
always_ff @(posedge clk) begin
    if (~q_flush & (q_we != WE_NONE)) begin
        q_data[q_wptr[ADR_W-1:0]] <= lo_sel ? rdata[HALF_W-1:0] : rdata[2*HALF_W-1:HALF_W];
        q_err[q_wptr[ADR_W-1:0]]  <= evt.er;
        if (q_we == WE_FULL) begin
            q_data[q_wptr_inc[ADR_W-1:0]] <= rdata[2*HALF_W-1:HALF_W];
            q_err[q_wptr_inc[ADR_W-1:0]]  <= evt.er;
        end
    end
end

// --------------------------------------------------------------------------
// Decode side
// --------------------------------------------------------------------------
assign q_data_head   = q_data[q_rptr[ADR_W-1:0]];
assign q_data_next   = q_data[ADR_W'(q_rptr + 1'b1)];
assign q_err_head    = q_err[q_rptr[ADR_W-1:0]];
assign q_head_single = ~(&q_data_head[1:0]) | q_err_head;

always_comb begin
    idu.vd       = 1'b0;
    idu.imem_err = 1'b0;
    if (~q_empty) begin
        // A lone upper-RVI half waits for its partner
        idu.vd       = (q_ocpd_h == OCPD_W'(1)) ? q_head_single : 1'b1;
        idu.imem_err = q_err_head;
    end
    idu.instr = q_head_single ? `IFU_IMEM_DWIDTH'(q_data_head) : {q_data_next, q_data_head};
end

endmodule
`default_nettype wire

//--- source/fetch_unit.sv
// Top of the instruction fetch unit: control FSM, request tracking,
// response classification and the halfword queue feeding decode
`timescale 1ns/1ns
`default_nettype none
`include "ifu_consts.svh"

module fetch_unit
    import ifu_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire redirect_t          redir,
    input  wire                     imem_req_ack,
    output logic                    imem_req,
    output logic [`IFU_XLEN-1:0]    imem_addr,
    input  wire imem_resp_t         imem_resp,
    input  wire                     idu_rdy,
    output idu_out_t                idu,
    output logic                    busy
);

fsm_state_e                 state;
resp_evt_t                  evt;        // Response decoded once
q_we_e                      q_we;
logic                       lo_sel;
logic [`IFU_Q_FREE_W_W-1:0] q_free_w;

fetch_fsm u_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .redir      (redir),
    .evt        (evt),
    .state      (state),
    .busy       (busy)
);

txn_tracker u_txn (
    .clk            (clk),
    .rst_n          (rst_n),
    .redir          (redir),
    .resp           (imem_resp.resp),
    .state          (state),
    .q_free_w       (q_free_w),
    .imem_req_ack   (imem_req_ack),
    .imem_req       (imem_req),
    .imem_addr      (imem_addr),
    .evt            (evt)
);

rdata_classifier u_cls (
    .clk        (clk),
    .rst_n      (rst_n),
    .redir      (redir),
    .evt        (evt),
    .rdata      (imem_resp.rdata),
    .q_we       (q_we),
    .lo_sel     (lo_sel)
);

instr_queue u_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .redir      (redir),
    .evt        (evt),
    .rdata      (imem_resp.rdata),
    .q_we       (q_we),
    .lo_sel     (lo_sel),
    .idu_rdy    (idu_rdy),
    .q_free_w   (q_free_w),
    .idu        (idu)
);

endmodule
`default_nettype wire

//--- verif/tb_fetch_unit.sv
// Testbench for the fetch unit with a random-latency instruction memory,
// a reference walk of the program stream and assertions on every decode handshake
// Runs aligned, unaligned, redirect, memory error and stop_fetch sequences
`timescale 1ns/1ns
`default_nettype none
`include "ifu_consts.svh"

module tb_fetch_unit
    import ifu_pkg::*;
();

localparam int PROG_HALVES   = 512;                      // 1 KB program image
localparam int MAX_PENDING   = (1 << `IFU_TXN_CNT_W) - 1;
localparam logic [31:0] ERR_ADDR = 32'h0000_0300;
localparam int N_ALIGNED     = 60;
localparam int N_UNALIGNED   = 40;
localparam int N_PRE_REDIR   = 10;
localparam int N_REDIR       = 40;
localparam int N_STOP        = 20;
localparam int N_TOTAL       = N_ALIGNED + N_UNALIGNED + N_PRE_REDIR + N_REDIR + N_STOP + 20;
localparam int LIMIT         = 20 * N_TOTAL + 400;      // Worst case per instruction

logic                   clk;
logic                   rst_n;
redirect_t              redir;
logic                   imem_req_ack;
logic                   imem_req;
logic [`IFU_XLEN-1:0]   imem_addr;
imem_resp_t             imem_resp;
logic                   idu_rdy;
idu_out_t               idu;
logic                   busy;

logic [15:0]    prog [PROG_HALVES];
logic [31:0]    rng = 32'h9ea1;
logic [31:0]    addr_q [$];        // Accepted read addresses in issue order
int             due_q [$];
int             last_due = 0;
int             cycle_cnt = 0;
int             consumed = 0;
int             outstanding = 0;
int             checks = 0;
int             errors = 0;
logic [31:0]    exp_pc = '0;
logic [31:0]    exp_fetch = '0;    // Word address of the next read
logic           stream_on = 1'b0;
logic           started = 1'b0;
logic           stop_chk = 1'b0;
logic           err_seen = 1'b0;
int             err_phase = 0;     // Steps to 2 once the FSM must be idle after an error

fetch_unit u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .redir          (redir),
    .imem_req_ack   (imem_req_ack),
    .imem_req       (imem_req),
    .imem_addr      (imem_addr),
    .imem_resp      (imem_resp),
    .idu_rdy        (idu_rdy),
    .idu            (idu),
    .busy           (busy)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

// --------------------------------------------------------------------------
// Helpers
// --------------------------------------------------------------------------
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [8:0] idx;
    idx = {addr[9:2], 1'b0};
    return {prog[idx + 9'd1], prog[idx]};
endfunction

// Reference walk where both low bits set mark a 32-bit instruction
function automatic int ref_len(input logic [31:0] pc);
    return (&prog[pc[9:1]][1:0]) ? 4 : 2;
endfunction

function automatic logic [31:0] ref_instr(input logic [31:0] pc);
    logic [8:0] nxt;
    nxt = pc[9:1] + 9'd1;
    if (ref_len(pc) == 4) begin
        return {prog[nxt], prog[pc[9:1]]};
    end
    return {16'h0000, prog[pc[9:1]]};
endfunction

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
endtask

task automatic report_failure(input string msg);
    errors++;
    $display("Failure at t=%0t: %s", $time, msg);
endtask

task automatic print_counts();
    $display("Checks %0d, errors %0d, instructions consumed %0d", checks, errors, consumed);
endtask

task automatic start_stream(input logic [31:0] pc);
    redir.new_pc     <= pc;
    redir.new_pc_req <= 1'b1;
    @(posedge clk);
    redir.new_pc_req <= 1'b0;
endtask

task automatic wait_consumed(input int n);
    int target;
    target = consumed + n;
    while (consumed < target) @(posedge clk);
endtask

task automatic wait_for_accept();
    while (!(imem_req && imem_req_ack)) @(posedge clk);
endtask

// Held until every read in flight has been answered and flushed
task automatic stop_stream();
    redir.stop_fetch <= 1'b1;
    repeat (2) @(posedge clk);
    while (outstanding != 0) @(posedge clk);
    redir.stop_fetch <= 1'b0;
endtask

// --------------------------------------------------------------------------
// Memory responder and stream checker on pre-edge values
// --------------------------------------------------------------------------
always @(posedge clk) begin
    int due;
    logic [31:0] want_addr;
    cycle_cnt <= cycle_cnt + 1;
    rng = xorshift32(rng);
    if (rst_n) begin
        if (!started && !redir.new_pc_req) begin
            check_val("imem_req", imem_req, 0);
            check_val("idu.vd", idu.vd, 0);
            check_val("busy", busy, 0);
        end
        if (imem_req) begin
            check_val("imem_addr[1:0]", imem_addr[1:0], 0);
            want_addr = redir.new_pc_req ? {redir.new_pc[31:2], 2'b00} : exp_fetch;
            check_val("imem_addr", imem_addr, want_addr);
        end
        if (redir.new_pc_req) begin
            exp_fetch = {redir.new_pc[31:2], 2'b00};
        end
        if (imem_req && imem_req_ack) begin
            exp_fetch = exp_fetch + 4;
        end
        if (stop_chk) begin
            check_val("busy", busy, 0);
            check_val("idu.vd", idu.vd, 0);
        end
        stop_chk = redir.stop_fetch;
        if (err_phase == 2 && !redir.new_pc_req) begin
            check_val("imem_req", imem_req, 0);
            check_val("busy", busy, 0);
        end
        if (redir.new_pc_req) begin
            err_phase = 0;
        end else if (err_phase == 1) begin
            err_phase = 2;
        end

        if (idu.vd && idu_rdy) begin
            assert (stream_on) else report_failure("instruction consumed with no stream");
            if (exp_pc[31:2] == ERR_ADDR[31:2]) begin
                check_val("idu.imem_err", idu.imem_err, 1);
                err_seen <= 1'b1;
                exp_pc = exp_pc + 2;           // Error halfwords leave one at a time
            end else begin
                check_val("idu.instr", idu.instr, ref_instr(exp_pc));
                check_val("idu.imem_err", idu.imem_err, 0);
                exp_pc = exp_pc + ref_len(exp_pc);
            end
            consumed <= consumed + 1;
        end
        if (redir.new_pc_req) begin
            exp_pc    = redir.new_pc;
            stream_on = 1'b1;
            started   = 1'b1;
        end
        if (redir.stop_fetch) begin
            stream_on = 1'b0;
        end

        if (imem_req && imem_req_ack) begin
            due = cycle_cnt + 1 + (rng[5:4] % 3);   // Latency of 1 to 3 cycles
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            addr_q.push_back(imem_addr);
            due_q.push_back(due);
        end
        assert (addr_q.size() <= MAX_PENDING) else report_failure("too many reads outstanding");
        if (due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
            imem_resp.rdata <= mem_word(addr_q[0]);
            if (addr_q[0][31:2] == ERR_ADDR[31:2]) begin
                imem_resp.resp <= RESP_RDY_ER;
                err_phase = 1;
            end else begin
                imem_resp.resp <= RESP_RDY_OK;
            end
            void'(addr_q.pop_front());
            void'(due_q.pop_front());
        end else begin
            imem_resp.resp  <= RESP_IDLE;
            imem_resp.rdata <= '0;
        end
        outstanding  <= addr_q.size();
        idu_rdy      <= (rng[1:0] != 2'b00);    // Ready three cycles in four
        imem_req_ack <= (rng[3:2] != 2'b00);
    end
end

// --------------------------------------------------------------------------
// Stimulus
// --------------------------------------------------------------------------
initial begin
    rst_n           = 1'b0;
    redir           = '0;
    imem_req_ack    = 1'b0;
    imem_resp.resp  = RESP_IDLE;
    imem_resp.rdata = '0;
    idu_rdy         = 1'b0;
    for (int i = 0; i < PROG_HALVES; i++) begin
        rng = xorshift32(rng);
        prog[i] = rng[15:0];
        if (rng[16]) begin
            prog[i][1:0] = 2'b11;                // More 32-bit instructions
        end
    end
    prog[(ERR_ADDR - 2) >> 1][1:0] = 2'b00;     // No instruction spans the error word

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);

    start_stream(32'h0000_0000);
    wait_consumed(N_ALIGNED);
    start_stream(32'h0000_0102);
    wait_consumed(N_UNALIGNED);

    start_stream(32'h0000_0200);
    wait_consumed(N_PRE_REDIR);
    wait_for_accept();
    start_stream(32'h0000_0180);                // Old reads still in flight
    wait_consumed(N_REDIR);

    start_stream(ERR_ADDR - 32'h10);
    while (!err_seen) @(posedge clk);
    repeat (8) @(posedge clk);

    start_stream(32'h0000_0040);
    wait_consumed(N_STOP);
    stop_stream();
    repeat (6) @(posedge clk);

    print_counts();
    if (errors == 0) begin
        $display("TEST PASSED");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

initial begin
    wait (cycle_cnt >= LIMIT);
    $display("Timeout after %0d cycles, tests did not finish", LIMIT);
    print_counts();
    $display("TEST FAILED");
    $finish;
end

endmodule
`default_nettype wire

//--- src.f
+incdir+source
source/ifu_pkg.sv
source/fetch_fsm.sv
source/txn_tracker.sv
source/rdata_classifier.sv
source/instr_queue.sv
source/fetch_unit.sv
verif/tb_fetch_unit.sv
